// ==== flist.f ====
+incdir+verilog
verilog/axi_bridge_pkg.sv
verilog/line_req_if.sv
verilog/req_stage.sv
verilog/axi_rd_engine.sv
verilog/axi_wr_engine.sv
verilog/axi_line_bridge.sv
bench/axi_mem_model.sv
bench/tb_axi_line_bridge.sv

// ==== Makefile ====
# Verilator build and run of the AXI line bridge testbench

TOP  := tb_axi_line_bridge
SRCS := $(shell grep -v '^+' flist.f) verilog/axi_bridge_consts.svh

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source or the file list changes
obj_dir/V%: flist.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $*

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_axi_line_bridge.sv ====
// testbench top: clock, reset, stimulus table, checks, watchdog and summary
`default_nettype none
`include "axi_bridge_consts.svh"

module tb_axi_line_bridge;

  typedef struct packed {
    logic                    is_write;
    logic                    is_line;
    logic [`AXI_ADDR_W-1:0]  addr;
    logic [`LINE_W-1:0]      data;       // word rows use the low 64 bits
    logic [`AXI_STRB_W-1:0]  strb;
    logic                    exp_err;
  } row_t;

  localparam int NUM_ROWS = 13;
  localparam int LIMIT    = NUM_ROWS * 200;   // watchdog budget in cycles

  logic                     aclk;
  logic                     rst_n;
  logic                     rd_req, wr_req, rw_op;
  logic [2:0]               rd_size, wr_size;
  logic [`AXI_ADDR_W-1:0]   rd_addr, wr_addr;
  logic [`AXI_STRB_W-1:0]   wr_wstrb;
  logic [`LINE_W-1:0]       wr_wdata;
  wire                      rd_rdy, wr_rdy, ret_valid, ret_last, wr_done, wr_err;
  wire  [`AXI_DATA_W-1:0]   ret_data;
  wire  [`AXI_ADDR_W-1:0]   awaddr, araddr;
  wire  [`AXI_LEN_W-1:0]    awlen, arlen;
  wire  [2:0]               awsize, arsize, awprot, arprot;
  wire  [1:0]               awburst, arburst, bresp, rresp;
  wire  [3:0]               awcache, arcache;
  wire                      awlock, arlock, awvalid, awready, wlast, wvalid, wready;
  wire                      bvalid, bready, arvalid, arready, rlast, rvalid, rready;
  wire  [`AXI_DATA_W-1:0]   wdata, rdata;
  wire  [`AXI_STRB_W-1:0]   wstrb;

  row_t                     rows [NUM_ROWS];
  row_t                     cur_row;     // row in flight, for the address phase checks
  logic [`AXI_DATA_W-1:0]   sb [256];    // mirror of the model memory
  int                       err_cnt  = 0;
  int                       chk_cnt  = 0;
  int                       done_cnt = 0;
  int                       last_cnt = 0;
  int                       n_writes = 0;

  axi_line_bridge UUT (
    .i_aclk(aclk), .i_rst_n(rst_n), .i_rd_req(rd_req), .i_wr_req(wr_req),
    .i_rw_op(rw_op), .i_rd_size(rd_size), .i_wr_size(wr_size), .i_rd_addr(rd_addr),
    .i_wr_addr(wr_addr), .i_wr_wstrb(wr_wstrb), .i_wr_wdata(wr_wdata),
    .o_rd_rdy(rd_rdy), .o_wr_rdy(wr_rdy), .o_ret_valid(ret_valid), .o_ret_last(ret_last),
    .o_ret_data(ret_data), .o_wr_done(wr_done), .o_wr_err(wr_err),
    .o_awaddr(awaddr), .o_awlen(awlen), .o_awsize(awsize), .o_awburst(awburst),
    .o_awlock(awlock), .o_awcache(awcache), .o_awprot(awprot), .o_awvalid(awvalid),
    .i_awready(awready), .o_wdata(wdata), .o_wstrb(wstrb), .o_wlast(wlast),
    .o_wvalid(wvalid), .i_wready(wready), .i_bresp(bresp), .i_bvalid(bvalid),
    .o_bready(bready), .o_araddr(araddr), .o_arlen(arlen), .o_arsize(arsize),
    .o_arburst(arburst), .o_arlock(arlock), .o_arcache(arcache), .o_arprot(arprot),
    .o_arvalid(arvalid), .i_arready(arready), .i_rdata(rdata), .i_rresp(rresp),
    .i_rlast(rlast), .i_rvalid(rvalid), .o_rready(rready)
  );

  axi_mem_model u_mem (
    .i_aclk(aclk), .i_rst_n(rst_n), .i_awaddr(awaddr), .i_awvalid(awvalid),
    .o_awready(awready), .i_wdata(wdata), .i_wstrb(wstrb), .i_wlast(wlast),
    .i_wvalid(wvalid), .o_wready(wready), .o_bresp(bresp), .o_bvalid(bvalid),
    .i_bready(bready), .i_araddr(araddr), .i_arlen(arlen), .i_arvalid(arvalid),
    .o_arready(arready), .o_rdata(rdata), .o_rresp(rresp), .o_rlast(rlast),
    .o_rvalid(rvalid), .i_rready(rready)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // watchdog
  initial begin
    repeat (LIMIT) @(posedge aclk);
    $display("timeout: a request did not complete within %0d cycles", LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  // completion pulses counted over the whole run
  always @(negedge aclk) begin
    if (rst_n && wr_done) done_cnt = done_cnt + 1;
    if (rst_n && ret_valid && ret_last) last_cnt = last_cnt + 1;
  end

  // burst shape on every address handshake
  always @(negedge aclk) begin
    if (rst_n && awvalid && awready) begin
      check_addr_phase("o_aw", awaddr, awlen, awsize, awburst, awlock, awcache, awprot);
    end
    if (rst_n && arvalid && arready) begin
      check_addr_phase("o_ar", araddr, arlen, arsize, arburst, arlock, arcache, arprot);
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr_phase(input string pfx, input logic [`AXI_ADDR_W-1:0] addr,
                                  input logic [`AXI_LEN_W-1:0] len, input logic [2:0] size,
                                  input logic [1:0] burst, input logic lock,
                                  input logic [3:0] cache, input logic [2:0] prot);
    logic [`AXI_ADDR_W-1:0] exp_addr;
    logic [`AXI_LEN_W-1:0]  exp_len;
    exp_addr = cur_row.is_line ? {cur_row.addr[`AXI_ADDR_W-1:5], 5'd0} : cur_row.addr;
    exp_len  = cur_row.is_line ? `AXI_LEN_W'(`LINE_BEATS - 1) : '0;
    compare({pfx, "addr"}, 64'(addr), 64'(exp_addr));
    compare({pfx, "len"}, 64'(len), 64'(exp_len));
    compare({pfx, "size"}, 64'(size), 64'd3);     // 8 bytes, both line beats and words
    compare({pfx, "burst"}, 64'(burst), 64'd1);   // INCR
    compare({pfx, "lock"}, 64'(lock), 64'd0);
    compare({pfx, "cache"}, 64'(cache), 64'd0);
    compare({pfx, "prot"}, 64'(prot), 64'd0);
  endtask

  function automatic logic [`LINE_W-1:0] line_of(input logic [63:0] seed);
    return {~seed, seed + 64'h1111_1111_1111_1111, {seed[59:0], 4'h5}, seed};
  endfunction

  // ------------------------------------------------------------
  // stimulus table of write, line, address, data, strobe and error
  // ------------------------------------------------------------
  task automatic load_table();
    rows[0]  = '{1'b1, 1'b1, 32'h100, line_of(64'hdead_beef_0000_0001), 8'hff, 1'b0};
    rows[1]  = '{1'b0, 1'b1, 32'h100, '0, 8'h00, 1'b0};
    rows[2]  = '{1'b1, 1'b0, 32'h208, {192'd0, 64'h1122_3344_5566_7788}, 8'h35, 1'b0};
    rows[3]  = '{1'b0, 1'b0, 32'h208, '0, 8'h00, 1'b0};
    rows[4]  = '{1'b0, 1'b1, 32'h10c, '0, 8'h00, 1'b0};  // unaligned line read
    rows[5]  = '{1'b1, 1'b0, 32'h740, {192'd0, 64'hcafe_f00d_0bad_beef}, 8'hff, 1'b1};
    rows[6]  = '{1'b0, 1'b0, 32'h740, '0, 8'h00, 1'b0};
    rows[7]  = '{1'b1, 1'b1, 32'h300, line_of(64'h0bad_cafe_1234_5678), 8'hff, 1'b0};
    rows[8]  = '{1'b1, 1'b1, 32'h7e0, line_of(64'h5555_aaaa_3333_cccc), 8'hff, 1'b1};
    rows[9]  = '{1'b0, 1'b1, 32'h300, '0, 8'h00, 1'b0};
    rows[10] = '{1'b0, 1'b1, 32'h7e8, '0, 8'h00, 1'b0};
    rows[11] = '{1'b1, 1'b0, 32'h318, {192'd0, 64'h8899_aabb_ccdd_eeff}, 8'hc0, 1'b0};
    rows[12] = '{1'b0, 1'b1, 32'h304, '0, 8'h00, 1'b0};
  endtask

  task automatic run_row(input int n);
    row_t        r;
    logic [7:0]  base;
    int          beats;
    int          seen;
    int          fails_before;
    r            = rows[n];
    cur_row      = r;
    fails_before = err_cnt;
    beats        = r.is_line ? `LINE_BEATS : 1;
    base         = r.is_line ? {r.addr[10:5], 2'b00} : r.addr[10:3];
    @(posedge aclk);
    rw_op <= r.is_write;
    if (r.is_write) begin
      wr_req   <= 1'b1;
      wr_addr  <= r.addr;
      wr_size  <= r.is_line ? `LINE_SIZE_CODE : 3'd3;
      wr_wstrb <= r.strb;
      wr_wdata <= r.data;
    end else begin
      rd_req  <= 1'b1;
      rd_addr <= r.addr;
      rd_size <= r.is_line ? `LINE_SIZE_CODE : 3'd3;
    end
    @(negedge aclk);
    while (!(r.is_write ? wr_rdy : rd_rdy)) @(negedge aclk);
    @(posedge aclk);                     // accepted on this edge
    rd_req <= 1'b0;
    wr_req <= 1'b0;
    if (r.is_write) begin
      @(negedge aclk);
      while (!wr_done) @(negedge aclk);
      compare("o_wr_err", 64'(wr_err), 64'(r.exp_err));
      if (!r.exp_err && r.is_line) begin
        for (int k = 0; k < `LINE_BEATS; k++) begin
          sb[base + 8'(k)] = r.data[64*k +: 64];
        end
      end else if (!r.exp_err) begin
        for (int b = 0; b < `AXI_STRB_W; b++) begin
          if (r.strb[b]) sb[base][8*b +: 8] = r.data[8*b +: 8];
        end
      end
    end else begin
      seen = 0;
      do begin
        @(negedge aclk);
        if (ret_valid) begin
          compare("o_ret_data", ret_data, sb[base + 8'(seen)]);
          compare("o_ret_last", 64'(ret_last), 64'(seen == beats - 1));
          seen++;
        end
      end while (!(ret_valid && ret_last));
      compare("read beat count", 64'(seen), 64'(beats));
    end
    $display("row %0d %s %s @%08h: %s", n, r.is_write ? "write" : "read",
             r.is_line ? "line" : "word", r.addr, err_cnt == fails_before ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n    = 1'b0;
    rd_req   = 1'b0;
    wr_req   = 1'b0;
    rw_op    = 1'b0;
    rd_size  = 3'd0;
    wr_size  = 3'd0;
    rd_addr  = '0;
    wr_addr  = '0;
    wr_wstrb = '0;
    wr_wdata = '0;
    load_table();
    repeat (3) @(posedge aclk);
    rst_n <= 1'b1;
    @(negedge aclk);
    compare("o_rd_rdy", 64'(rd_rdy), 64'd1);
    compare("o_wr_rdy", 64'(wr_rdy), 64'd1);
    compare("o_arvalid", 64'(arvalid), 64'd0);
    compare("o_awvalid", 64'(awvalid), 64'd0);
    compare("o_wvalid", 64'(wvalid), 64'd0);
    compare("o_bready", 64'(bready), 64'd0);
    compare("o_rready", 64'(rready), 64'd0);
    compare("o_ret_valid", 64'(ret_valid), 64'd0);
    compare("o_wr_done", 64'(wr_done), 64'd0);
    for (int i = 0; i < 256; i++) begin
      sb[i[7:0]] = u_mem.mem[i[7:0]];
    end
    for (int n = 0; n < NUM_ROWS; n++) begin
      n_writes += int'(rows[n].is_write);
      run_row(n);
    end
    repeat (20) @(negedge aclk);         // catch stray extra completions
    compare("write completions", 64'(done_cnt), 64'(n_writes));
    compare("read completions", 64'(last_cnt), 64'(NUM_ROWS - n_writes));
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/axi_mem_model.sv ====
// behavioral AXI4 slave memory with random ready stalls and a write error window
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_mem_model #(
  parameter int                      WORDS    = 256,
  parameter logic [`AXI_ADDR_W-1:0]  ERR_BASE = 32'h0000_0700,
  parameter logic [`AXI_ADDR_W-1:0]  ERR_TOP  = 32'h0000_07ff
) (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  input  wire [`AXI_ADDR_W-1:0]   i_awaddr,
  input  wire                     i_awvalid,
  output logic                    o_awready,
  input  wire [`AXI_DATA_W-1:0]   i_wdata,
  input  wire [`AXI_STRB_W-1:0]   i_wstrb,
  input  wire                     i_wlast,
  input  wire                     i_wvalid,
  output logic                    o_wready,
  output logic [1:0]              o_bresp,
  output logic                    o_bvalid,
  input  wire                     i_bready,
  input  wire [`AXI_ADDR_W-1:0]   i_araddr,
  input  wire [`AXI_LEN_W-1:0]    i_arlen,
  input  wire                     i_arvalid,
  output logic                    o_arready,
  output logic [`AXI_DATA_W-1:0]  o_rdata,
  output logic [1:0]              o_rresp,
  output logic                    o_rlast,
  output logic                    o_rvalid,
  input  wire                     i_rready
);

  localparam int IDX_W = $clog2(WORDS);

  logic [`AXI_DATA_W-1:0]  mem [WORDS];
  logic [31:0]             rnd;          // stall source, new bits every cycle
  logic                    aw_busy;
  logic                    aw_err;       // burst falls in the error window
  logic [IDX_W-1:0]        w_idx;
  logic                    b_pend;
  logic                    r_busy;
  logic [IDX_W-1:0]        r_idx;
  logic [`AXI_LEN_W-1:0]   r_len;
  logic [`AXI_LEN_W-1:0]   r_beat;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every word gets a value tied to its full index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i[IDX_W-1:0]] = {~(32'h1000_0000 + i), 32'h5a5a_0000 ^ (i << 3)};
    end
  end

  assign o_awready = ~aw_busy & ~b_pend & rnd[0];
  assign o_wready  = aw_busy & rnd[1];
  assign o_arready = ~r_busy & rnd[2];
  assign o_bvalid  = b_pend;
  assign o_rdata   = mem[r_idx];
  assign o_rresp   = 2'b00;              // reads always OKAY
  assign o_rlast   = (r_beat == r_len);

  // ------------------------------------------------------------
  // write and read channel handling
  // ------------------------------------------------------------
  always @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rnd      <= 32'd56;
      aw_busy  <= 1'b0;
      aw_err   <= 1'b0;
      w_idx    <= '0;
      b_pend   <= 1'b0;
      o_bresp  <= 2'b00;
      r_busy   <= 1'b0;
      r_idx    <= '0;
      r_len    <= '0;
      r_beat   <= '0;
      o_rvalid <= 1'b0;
    end else begin
      rnd <= xorshift32(rnd);
      if (i_awvalid && o_awready) begin
        aw_busy <= 1'b1;
        w_idx   <= i_awaddr[IDX_W+2:3];
        aw_err  <= (i_awaddr >= ERR_BASE) && (i_awaddr <= ERR_TOP);
      end
      if (i_wvalid && o_wready) begin
        for (int b = 0; b < `AXI_STRB_W; b++) begin
          if (i_wstrb[b] && !aw_err) begin
            mem[w_idx][8*b +: 8] <= i_wdata[8*b +: 8];   // error window stays intact
          end
        end
        w_idx <= w_idx + 1'b1;
        if (i_wlast) begin
          aw_busy <= 1'b0;
          b_pend  <= 1'b1;
          o_bresp <= aw_err ? 2'b10 : 2'b00;              // SLVERR in the window
        end
      end
      if (o_bvalid && i_bready) begin
        b_pend <= 1'b0;
      end
      if (i_arvalid && o_arready) begin
        r_busy <= 1'b1;
        r_idx  <= i_araddr[IDX_W+2:3];
        r_len  <= i_arlen;
        r_beat <= '0;
      end
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;                                 // gap before next beat
        r_idx    <= r_idx + 1'b1;
        r_beat   <= r_beat + 1'b1;
        if (o_rlast) begin
          r_busy <= 1'b0;
        end
      end else if (r_busy && !o_rvalid && rnd[3]) begin
        o_rvalid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/axi_line_bridge.sv ====
// top level cache-side AXI4 master bridge wiring slot and burst engines
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_line_bridge (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  // core side
  input  wire                     i_rd_req,
  input  wire                     i_wr_req,
  input  wire                     i_rw_op,
  input  wire [2:0]               i_rd_size,
  input  wire [2:0]               i_wr_size,
  input  wire [`AXI_ADDR_W-1:0]   i_rd_addr,
  input  wire [`AXI_ADDR_W-1:0]   i_wr_addr,
  input  wire [`AXI_STRB_W-1:0]   i_wr_wstrb,
  input  wire [`LINE_W-1:0]       i_wr_wdata,
  output logic                    o_rd_rdy,
  output logic                    o_wr_rdy,
  output logic                    o_ret_valid,
  output logic                    o_ret_last,
  output logic [`AXI_DATA_W-1:0]  o_ret_data,
  output logic                    o_wr_done,
  output logic                    o_wr_err,
  // write address channel
  output logic [`AXI_ADDR_W-1:0]  o_awaddr,
  output logic [`AXI_LEN_W-1:0]   o_awlen,
  output logic [2:0]              o_awsize,
  output logic [1:0]              o_awburst,
  output logic                    o_awlock,
  output logic [3:0]              o_awcache,
  output logic [2:0]              o_awprot,
  output logic                    o_awvalid,
  input  wire                     i_awready,
  // write data and response
  output logic [`AXI_DATA_W-1:0]  o_wdata,
  output logic [`AXI_STRB_W-1:0]  o_wstrb,
  output logic                    o_wlast,
  output logic                    o_wvalid,
  input  wire                     i_wready,
  input  wire [1:0]               i_bresp,
  input  wire                     i_bvalid,
  output logic                    o_bready,
  // read address channel
  output logic [`AXI_ADDR_W-1:0]  o_araddr,
  output logic [`AXI_LEN_W-1:0]   o_arlen,
  output logic [2:0]              o_arsize,
  output logic [1:0]              o_arburst,
  output logic                    o_arlock,
  output logic [3:0]              o_arcache,
  output logic [2:0]              o_arprot,
  output logic                    o_arvalid,
  input  wire                     i_arready,
  // read data channel
  input  wire [`AXI_DATA_W-1:0]   i_rdata,
  input  wire [1:0]               i_rresp,
  input  wire                     i_rlast,
  input  wire                     i_rvalid,
  output logic                    o_rready
);

  line_req_if rd_req ();
  line_req_if wr_req ();

  assign o_awlock  = `AXI_LOCK_NORMAL;
  assign o_awcache = `AXI_CACHE_DEVICE;
  assign o_awprot  = `AXI_PROT_DATA;
  assign o_arlock  = `AXI_LOCK_NORMAL;
  assign o_arcache = `AXI_CACHE_DEVICE;
  assign o_arprot  = `AXI_PROT_DATA;

  req_stage u_req_stage (
    .i_aclk, .i_rst_n, .i_rd_req, .i_wr_req, .i_rw_op,
    .i_rd_size, .i_wr_size, .i_rd_addr, .i_wr_addr, .i_wr_wstrb, .i_wr_wdata,
    .o_rd_rdy, .o_wr_rdy,
    .rd_req (rd_req.req_stage),
    .wr_req (wr_req.req_stage)
  );

  axi_rd_engine u_rd_engine (
    .i_aclk, .i_rst_n,
    .rd_req (rd_req.engine),
    .i_arready, .i_rdata, .i_rresp, .i_rlast, .i_rvalid,
    .o_araddr, .o_arlen, .o_arsize, .o_arburst, .o_arvalid, .o_rready,
    .o_ret_valid, .o_ret_last, .o_ret_data
  );

  axi_wr_engine u_wr_engine (
    .i_aclk, .i_rst_n,
    .wr_req (wr_req.engine),
    .i_awready, .i_wready, .i_bresp, .i_bvalid,
    .o_awaddr, .o_awlen, .o_awsize, .o_awburst, .o_awvalid,
    .o_wdata, .o_wstrb, .o_wlast, .o_wvalid, .o_bready,
    .o_wr_done, .o_wr_err
  );

endmodule

`default_nettype wire

// ==== verilog/axi_wr_engine.sv ====
// write burst engine driving the AW, W and B channels with line serializer
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_wr_engine (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  line_req_if.engine              wr_req,
  input  wire                     i_awready,
  input  wire                     i_wready,
  input  wire [1:0]               i_bresp,
  input  wire                     i_bvalid,
  output logic [`AXI_ADDR_W-1:0]  o_awaddr,
  output logic [`AXI_LEN_W-1:0]   o_awlen,
  output logic [2:0]              o_awsize,
  output logic [1:0]              o_awburst,
  output logic                    o_awvalid,
  output logic [`AXI_DATA_W-1:0]  o_wdata,
  output logic [`AXI_STRB_W-1:0]  o_wstrb,
  output logic                    o_wlast,
  output logic                    o_wvalid,
  output logic                    o_bready,
  output logic                    o_wr_done,
  output logic                    o_wr_err
);

  axi_bridge_pkg::wr_state_e  state;
  logic                       take_q;
  logic                       grab;
  logic                       aw_fire;
  logic                       w_fire;
  logic                       b_fire;
  logic [`LINE_W-1:0]         line_buf;   // lowest beat sits in the bottom
  logic [`AXI_LEN_W-1:0]      beat_cnt;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = o_bready & i_bvalid;
  assign grab    = (state == axi_bridge_pkg::WR_IDLE) & wr_req.valid & ~take_q;

  assign wr_req.take = take_q;

  // ------------------------------------------------------------
  // write FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state     <= axi_bridge_pkg::WR_IDLE;
      take_q    <= 1'b0;
      o_wr_done <= 1'b0;
      o_wr_err  <= 1'b0;
    end else begin
      take_q    <= grab;
      o_wr_done <= b_fire;                 // registered pulse
      o_wr_err  <= b_fire & (|i_bresp);
      case (state)
        axi_bridge_pkg::WR_IDLE: if (take_q) state <= axi_bridge_pkg::WR_ADDR;
        axi_bridge_pkg::WR_ADDR: if (aw_fire) state <= axi_bridge_pkg::WR_DATA;
        axi_bridge_pkg::WR_DATA: if (w_fire && o_wlast) state <= axi_bridge_pkg::WR_RESP;
        axi_bridge_pkg::WR_RESP: if (b_fire) state <= axi_bridge_pkg::WR_IDLE;
        default:                 state <= axi_bridge_pkg::WR_IDLE;
      endcase
    end
  end

  // burst shape and payload latched on load
  always_ff @(posedge i_aclk) begin
    if (grab) begin
      if (wr_req.kind == axi_bridge_pkg::KIND_LINE) begin
        o_awaddr <= {wr_req.addr[`AXI_ADDR_W-1:`LINE_OFF_W], {`LINE_OFF_W{1'b0}}};
        o_awlen  <= `AXI_LEN_W'(`LINE_BEATS - 1);
        o_awsize <= `LINE_BEAT_SIZE;
        o_wstrb  <= {`AXI_STRB_W{1'b1}};
      end else begin
        o_awaddr <= wr_req.addr;
        o_awlen  <= '0;
        o_awsize <= wr_req.size;
        o_wstrb  <= wr_req.wstrb;
      end
    end
  end

  // beat serializer
  always_ff @(posedge i_aclk) begin
    if (grab) begin
      line_buf <= wr_req.data;
      beat_cnt <= '0;
    end else if (w_fire) begin
      line_buf <= line_buf >> `AXI_DATA_W;
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign o_awburst = axi_bridge_pkg::BURST_INCR;
  assign o_awvalid = (state == axi_bridge_pkg::WR_ADDR);
  assign o_wvalid  = (state == axi_bridge_pkg::WR_DATA);
  assign o_wdata   = line_buf[`AXI_DATA_W-1:0];
  assign o_wlast   = (beat_cnt == o_awlen);
  assign o_bready  = (state == axi_bridge_pkg::WR_RESP);

  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr) && $stable(o_awlen));

  // beat data and its last flag hold through a wready stall
  a_w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_wlast) && $stable(o_wdata));

endmodule

`default_nettype wire

// ==== verilog/axi_rd_engine.sv ====
// read burst engine driving the AR and R channels back to the core
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_rd_engine (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  line_req_if.engine              rd_req,
  input  wire                     i_arready,
  input  wire [`AXI_DATA_W-1:0]   i_rdata,
  input  wire [1:0]               i_rresp,
  input  wire                     i_rlast,
  input  wire                     i_rvalid,
  output logic [`AXI_ADDR_W-1:0]  o_araddr,
  output logic [`AXI_LEN_W-1:0]   o_arlen,
  output logic [2:0]              o_arsize,
  output logic [1:0]              o_arburst,
  output logic                    o_arvalid,
  output logic                    o_rready,
  output logic                    o_ret_valid,
  output logic                    o_ret_last,
  output logic [`AXI_DATA_W-1:0]  o_ret_data
);

  axi_bridge_pkg::rd_state_e  state;
  logic                       take_q;
  logic                       grab;
  logic                       ar_fire;
  logic                       r_fire;
  logic [`AXI_LEN_W-1:0]      beat_cnt;   // beats seen in this burst

  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready & i_rvalid;
  assign grab    = (state == axi_bridge_pkg::RD_IDLE) & rd_req.valid & ~take_q;

  assign rd_req.take = take_q;

  // ------------------------------------------------------------
  // read FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state  <= axi_bridge_pkg::RD_IDLE;
      take_q <= 1'b0;
    end else begin
      take_q <= grab;
      case (state)
        axi_bridge_pkg::RD_IDLE: if (take_q) state <= axi_bridge_pkg::RD_ADDR;
        axi_bridge_pkg::RD_ADDR: if (ar_fire) state <= axi_bridge_pkg::RD_DATA;
        axi_bridge_pkg::RD_DATA: if (r_fire && i_rlast) state <= axi_bridge_pkg::RD_IDLE;
        default:                 state <= axi_bridge_pkg::RD_IDLE;
      endcase
    end
  end

  // burst shape latched when the request is loaded
  always_ff @(posedge i_aclk) begin
    if (grab) begin
      if (rd_req.kind == axi_bridge_pkg::KIND_LINE) begin
        o_araddr <= {rd_req.addr[`AXI_ADDR_W-1:`LINE_OFF_W], {`LINE_OFF_W{1'b0}}};
        o_arlen  <= `AXI_LEN_W'(`LINE_BEATS - 1);
        o_arsize <= `LINE_BEAT_SIZE;
      end else begin
        o_araddr <= rd_req.addr;
        o_arlen  <= '0;
        o_arsize <= rd_req.size;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (grab) begin
      beat_cnt <= '0;
    end else if (r_fire) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign o_arburst   = axi_bridge_pkg::BURST_INCR;
  assign o_arvalid   = (state == axi_bridge_pkg::RD_ADDR);
  assign o_rready    = (state == axi_bridge_pkg::RD_DATA);
  assign o_ret_valid = r_fire;             // beats go straight through
  assign o_ret_last  = i_rlast;
  assign o_ret_data  = i_rdata;

  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arlen));

  a_rlast_len: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire && i_rlast |-> beat_cnt == o_arlen);

  // slave answers every beat with a defined response
  a_rresp_known: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire |-> !$isunknown({i_rresp, i_rlast}));

endmodule

`default_nettype wire

// ==== verilog/req_stage.sv ====
// one-entry request slot feeding the read and write burst engines
`default_nettype none
`include "axi_bridge_consts.svh"

module req_stage (
  input  wire                     i_aclk,
  input  wire                     i_rst_n,
  input  wire                     i_rd_req,
  input  wire                     i_wr_req,
  input  wire                     i_rw_op,     // 1 selects the write request
  input  wire [2:0]               i_rd_size,
  input  wire [2:0]               i_wr_size,
  input  wire [`AXI_ADDR_W-1:0]   i_rd_addr,
  input  wire [`AXI_ADDR_W-1:0]   i_wr_addr,
  input  wire [`AXI_STRB_W-1:0]   i_wr_wstrb,
  input  wire [`LINE_W-1:0]       i_wr_wdata,
  output logic                    o_rd_rdy,
  output logic                    o_wr_rdy,
  line_req_if.req_stage           rd_req,
  line_req_if.req_stage           wr_req
);

  logic                       slot_valid;
  logic                       slot_is_write;
  axi_bridge_pkg::req_kind_e  slot_kind;
  logic [`AXI_ADDR_W-1:0]     slot_addr;
  logic [2:0]                 slot_size;
  logic [`AXI_STRB_W-1:0]     slot_wstrb;
  logic [`LINE_W-1:0]         slot_data;
  logic                       rd_load;
  logic                       wr_load;
  logic                       slot_take;
  logic [2:0]                 cap_size;

  assign o_rd_rdy  = ~slot_valid;
  assign o_wr_rdy  = ~slot_valid;
  assign rd_load   = i_rd_req & ~i_rw_op & o_rd_rdy;
  assign wr_load   = i_wr_req & i_rw_op & o_wr_rdy & ~rd_load;  // read wins
  assign slot_take = rd_req.take | wr_req.take;
  assign cap_size  = rd_load ? i_rd_size : i_wr_size;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      slot_valid <= 1'b0;
    end else if (rd_load || wr_load) begin
      slot_valid <= 1'b1;
    end else if (slot_take) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (rd_load || wr_load) begin
      slot_is_write <= wr_load;
      slot_kind     <= (cap_size == `LINE_SIZE_CODE) ? axi_bridge_pkg::KIND_LINE
                                                      : axi_bridge_pkg::KIND_WORD;
      slot_addr     <= rd_load ? i_rd_addr : i_wr_addr;
      slot_size     <= cap_size;
      slot_wstrb    <= i_wr_wstrb;
      slot_data     <= i_wr_wdata;
    end
  end

  // ------------------------------------------------------------
  // present the slot to the engine that matches its direction
  // ------------------------------------------------------------
  assign rd_req.valid    = slot_valid & ~slot_is_write;
  assign rd_req.is_write = slot_is_write;
  assign rd_req.kind     = slot_kind;
  assign rd_req.addr     = slot_addr;
  assign rd_req.size     = slot_size;
  assign rd_req.wstrb    = slot_wstrb;
  assign rd_req.data     = slot_data;

  assign wr_req.valid    = slot_valid & slot_is_write;
  assign wr_req.is_write = slot_is_write;
  assign wr_req.kind     = slot_kind;
  assign wr_req.addr     = slot_addr;
  assign wr_req.size     = slot_size;
  assign wr_req.wstrb    = slot_wstrb;
  assign wr_req.data     = slot_data;

  // full slot only empties through the engine it is aimed at
  a_slot_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    slot_take |-> slot_valid && (wr_req.take == slot_is_write)
                             && (rd_req.take == !slot_is_write));

endmodule

`default_nettype wire

// ==== verilog/line_req_if.sv ====
// captured request handoff from the request slot to a burst engine
`default_nettype none
`include "axi_bridge_consts.svh"

interface line_req_if;

  logic                       valid;      // slot full for this engine
  logic                       is_write;
  axi_bridge_pkg::req_kind_e  kind;
  logic [`AXI_ADDR_W-1:0]     addr;
  logic [2:0]                 size;
  logic [`AXI_STRB_W-1:0]     wstrb;
  logic [`LINE_W-1:0]         data;
  logic                       take;       // one cycle, empties the slot

  modport req_stage (
    output valid, is_write, kind, addr, size, wstrb, data,
    input  take
  );

  modport engine (
    input  valid, is_write, kind, addr, size, wstrb, data,
    output take
  );

endinterface

`default_nettype wire

// ==== verilog/axi_bridge_pkg.sv ====
// request kind, engine state and burst type enums for the bridge
`default_nettype none

package axi_bridge_pkg;

  // decoded from the core size code at capture
  typedef enum logic {
    KIND_WORD,
    KIND_LINE
  } req_kind_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,                            // arvalid held
    RD_DATA                             // rready held until rlast
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,                            // awvalid held
    WR_DATA,                            // beats shifted out
    WR_RESP                             // waiting on b channel
  } wr_state_e;

  // AxBURST encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

endpackage

`default_nettype wire

// ==== verilog/axi_bridge_consts.svh ====
// bus widths, cache line geometry and fixed axi attribute macros
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// ------------------------------------------------------------
// bus geometry
// ------------------------------------------------------------
`define AXI_ADDR_W        32
`define AXI_DATA_W        64
`define AXI_STRB_W        8
`define AXI_LEN_W         8

// ------------------------------------------------------------
// cache line geometry
// ------------------------------------------------------------
`define LINE_W            256
`define LINE_BEATS        4
`define LINE_OFF_W        5          // 32 byte line
`define LINE_SIZE_CODE    3'b100     // core size code for a whole line
`define LINE_BEAT_SIZE    3'd3       // 8 bytes per beat

// fixed attributes: normal access, device non-bufferable, unprivileged data
`define AXI_LOCK_NORMAL   1'b0
`define AXI_CACHE_DEVICE  4'b0000
`define AXI_PROT_DATA     3'b000

`endif
